// File: rewardTop.f
hw/packetPkg.sv
hw/rewardPkg.sv
hw/decisionIf.sv
hw/hbTimeout.sv
hw/rewardDecide.sv
hw/packetPacker.sv
hw/rewardTop.sv
tests/rewardTop_properties.sv
tests/rewardTop_tb.sv

// File: Bender.yml
package:
  name: rewardTop

sources:
  - files:
      - hw/packetPkg.sv
      - hw/rewardPkg.sv
      - hw/decisionIf.sv
      - hw/hbTimeout.sv
      - hw/rewardDecide.sv
      - hw/packetPacker.sv
      - hw/rewardTop.sv
  - target: test
    files:
      - tests/rewardTop_properties.sv
      - tests/rewardTop_tb.sv

// File: tests/rewardTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rewardTop_tb;

    import packetPkg::*;

    // short timeout keeps the expiry tests quick
    localparam int TIMEOUT    = 10;
    localparam int INV_LIMIT  = 4;
    // worst output wait is a full expiry plus both stages
    localparam int OUT_WAIT   = TIMEOUT + 10;
    localparam int IN_WAIT    = 10;
    // tests need a few hundred cycles so this leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    logic       clk;
    logic       nrst;
    logic       inValid;
    logic       inReady;
    pktHeader_t inPkt;
    logic       sendValid;
    logic       sendReady;
    logic       role;
    logic       lowEnergy;
    nodeWord_t  myNodeID;
    nodeWord_t  hopsFromSink;
    nodeWord_t  myQValue;
    nodeWord_t  myEnergy;
    nodeWord_t  hopsFromCH;
    nodeWord_t  chosenCH;
    nodeWord_t  chosenHop;
    logic       outValid;
    logic       outReady;
    pktType_e   outType;
    nodeWord_t  outSourceID;
    nodeWord_t  outSourceHops;
    nodeWord_t  outQValue;
    nodeWord_t  outEnergy;
    nodeWord_t  outHopsFromCH;
    nodeWord_t  outChosenCH;
    nodeWord_t  outDestID;
    integer     seed;
    int         cycleCount;

    rewardTop #(
        .TIMEOUT_CYCLES(TIMEOUT),
        .MAX_INV_HOPS  (INV_LIMIT)
    ) rewardTop_i (
        .clk          (clk),
        .nrst         (nrst),
        .inValid      (inValid),
        .inReady      (inReady),
        .inType       (inPkt.pktType),
        .inSourceID   (inPkt.sourceID),
        .inSourceHops (inPkt.sourceHops),
        .inQValue     (inPkt.qValue),
        .inEnergy     (inPkt.energy),
        .inHopsFromCH (inPkt.hopsFromCH),
        .inChosenCH   (inPkt.chosenCH),
        .inDestID     (inPkt.destID),
        .sendValid    (sendValid),
        .sendReady    (sendReady),
        .role         (role),
        .lowEnergy    (lowEnergy),
        .myNodeID     (myNodeID),
        .hopsFromSink (hopsFromSink),
        .myQValue     (myQValue),
        .myEnergy     (myEnergy),
        .hopsFromCH   (hopsFromCH),
        .chosenCH     (chosenCH),
        .chosenHop    (chosenHop),
        .outValid     (outValid),
        .outReady     (outReady),
        .outType      (outType),
        .outSourceID  (outSourceID),
        .outSourceHops(outSourceHops),
        .outQValue    (outQValue),
        .outEnergy    (outEnergy),
        .outHopsFromCH(outHopsFromCH),
        .outChosenCH  (outChosenCH),
        .outDestID    (outDestID)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // run budget
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            stopRun("simulation ran past its cycle budget");
        end
    end

    // bound checker failures
    always @(rewardTop_i.rewardTop_properties_i.failCount) begin
        if (rewardTop_i.rewardTop_properties_i.failCount != 0) begin
            stopRun("a bound handshake or lock assertion failed");
        end
    end

    task automatic stopRun(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic nodeWord_t randWord();
        randWord = nodeWord_t'($random(seed));
    endfunction

    // random fields with the tested ones pinned by the caller
    function automatic pktHeader_t randHeader(input pktType_e t);
        pktHeader_t h;
        h.pktType    = t;
        h.sourceID   = randWord();
        h.sourceHops = randWord();
        h.qValue     = randWord();
        h.energy     = randWord();
        h.hopsFromCH = randWord();
        h.chosenCH   = randWord();
        h.destID     = randWord();
        return h;
    endfunction

    // an address that misses this node
    function automatic nodeWord_t otherNode();
        nodeWord_t w;
        w = randWord();
        if (w == myNodeID) begin
            w = ~w;
        end
        return w;
    endfunction

    function automatic nodeWord_t expectedHop();
        return (hopsFromSink == 16'd1) ? SINK_ID : chosenHop;
    endfunction

    function automatic pktHeader_t hbRipple(input pktHeader_t pkt);
        pktHeader_t h;
        h            = '0;
        h.pktType    = HB;
        h.sourceID   = myNodeID;
        h.sourceHops = pkt.sourceHops + 16'd1;
        h.destID     = BROADCAST_ID;
        return h;
    endfunction

    function automatic pktHeader_t invRipple(input pktHeader_t pkt);
        pktHeader_t h;
        h            = '0;
        h.pktType    = INV;
        h.sourceID   = pkt.sourceID;
        h.qValue     = pkt.qValue;
        h.hopsFromCH = pkt.hopsFromCH + 16'd1;
        h.destID     = BROADCAST_ID;
        return h;
    endfunction

    function automatic pktHeader_t forwarded(input pktHeader_t pkt);
        pktHeader_t h;
        h        = pkt;
        h.destID = expectedHop();
        return h;
    endfunction

    // locally originated DATA or SOS
    function automatic pktHeader_t ownPacket(input pktType_e t);
        pktHeader_t h;
        h            = '0;
        h.pktType    = t;
        h.sourceID   = myNodeID;
        h.sourceHops = hopsFromSink;
        h.qValue     = myQValue;
        h.energy     = myEnergy;
        h.hopsFromCH = hopsFromCH;
        h.chosenCH   = chosenCH;
        h.destID     = expectedHop();
        return h;
    endfunction

    task automatic offerPacket(input pktHeader_t pkt);
        @(negedge clk);
        inPkt   = pkt;
        inValid = 1'b1;
    endtask

    // hold the offer until the handshake edge and then withdraw
    task automatic waitInAccept();
        int n;
        n = 0;
        @(posedge clk);
        while (!inReady) begin
            n++;
            if (n >= IN_WAIT) begin
                stopRun("inReady never rose for an offered packet");
            end
            @(posedge clk);
        end
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic sendPacket(input pktHeader_t pkt);
        offerPacket(pkt);
        waitInAccept();
    endtask

    task automatic requestSend();
        int n;
        n = 0;
        @(negedge clk);
        sendValid = 1'b1;
        @(posedge clk);
        while (!sendReady) begin
            n++;
            if (n >= IN_WAIT) begin
                stopRun("sendReady never rose for a local send request");
            end
            @(posedge clk);
        end
        @(negedge clk);
        sendValid = 1'b0;
    endtask

    // fields checked on the transfer edge
    task automatic expectPacket(input pktHeader_t want, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!(outValid && outReady)) begin
            n++;
            if (n >= OUT_WAIT) begin
                stopRun({"no output packet arrived for ", what});
            end
            @(posedge clk);
        end
        check(outType, want.pktType, {what, ": type"});
        check(outSourceID, want.sourceID, {what, ": sourceID"});
        check(outSourceHops, want.sourceHops, {what, ": sourceHops"});
        check(outQValue, want.qValue, {what, ": qValue"});
        check(outEnergy, want.energy, {what, ": energy"});
        check(outHopsFromCH, want.hopsFromCH, {what, ": hopsFromCH"});
        check(outChosenCH, want.chosenCH, {what, ": chosenCH"});
        check(outDestID, want.destID, {what, ": destID"});
    endtask

    task automatic expectNone(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check(outValid, 1'b0, "outValid for an event that earns no answer");
        end
    endtask

    // DATA for someone else is dropped but clears the lock
    task automatic clearLock();
        pktHeader_t pkt;
        pkt        = randHeader(DATA);
        pkt.destID = otherNode();
        sendPacket(pkt);
        expectNone(4);
    endtask

    task automatic testHeartbeat();
        pktHeader_t pkt;
        pkt = randHeader(HB);
        sendPacket(pkt);
        expectPacket(hbRipple(pkt), "first heartbeat");
        // locked now so repeat is swallowed
        sendPacket(randHeader(HB));
        expectNone(4);
        clearLock();
    endtask

    task automatic testInvitation();
        pktHeader_t pkt;
        pkt            = randHeader(INV);
        pkt.hopsFromCH = nodeWord_t'(INV_LIMIT - 2);
        sendPacket(pkt);
        expectPacket(invRipple(pkt), "invitation below limit");
        pkt            = randHeader(INV);
        pkt.hopsFromCH = nodeWord_t'(INV_LIMIT);
        sendPacket(pkt);
        expectNone(4);
    endtask

    task automatic testTimeout();
        pktHeader_t pkt;
        pktHeader_t want;
        pkt = randHeader(HB);
        sendPacket(pkt);
        expectPacket(hbRipple(pkt), "heartbeat arming the timer")
        ;
        // quiet for the whole idle period
        expectNone(TIMEOUT);
        want            = '0;
        want.pktType    = MR;
        want.sourceID   = myNodeID;
        want.sourceHops = hopsFromSink;
        want.qValue     = myQValue;
        want.energy     = myEnergy;
        want.hopsFromCH = hopsFromCH;
        want.destID     = chosenCH;
        expectPacket(want, "membership request on timeout");
        clearLock();
        // cluster head role re-armed with a fresh heartbeat
        @(negedge clk);
        role = 1'b1;
        pkt  = randHeader(HB);
        sendPacket(pkt);
        expectPacket(hbRipple(pkt), "heartbeat re-arming the lock");
        expectNone(TIMEOUT);
        want          = '0;
        want.pktType  = CHT;
        want.sourceID = myNodeID;
        want.qValue   = myQValue;
        want.chosenCH = myNodeID;
        want.destID   = BROADCAST_ID;
        expectPacket(want, "timeslot announcement on timeout");
        clearLock();
        @(negedge clk);
        role = 1'b0;
    endtask

    task automatic testForwarding();
        pktHeader_t pkt;
        pkt        = randHeader(DATA);
        pkt.destID = myNodeID;
        sendPacket(pkt);
        expectPacket(forwarded(pkt), "DATA forwarded to chosen hop");
        // one hop out the sink is next
        @(negedge clk);
        hopsFromSink = 16'd1;
        pkt          = randHeader(DATA);
        pkt.destID   = myNodeID;
        sendPacket(pkt);
        expectPacket(forwarded(pkt), "DATA forwarded to sink");
        @(negedge clk);
        hopsFromSink = 16'd3;
        clearLock();
    endtask

    task automatic testOrigination();
        requestSend();
        expectPacket(ownPacket(DATA), "originated DATA");
        @(negedge clk);
        lowEnergy = 1'b1;
        requestSend();
        expectPacket(ownPacket(SOS), "originated SOS");
        @(negedge clk);
        lowEnergy = 1'b0;
    endtask

    task automatic testBackPressure();
        pktHeader_t first;
        pktHeader_t second;
        pktHeader_t third;
        first             = randHeader(DATA);
        first.destID      = myNodeID;
        second            = randHeader(INV);
        second.hopsFromCH = 16'd1;
        third             = randHeader(SOS);
        third.destID      = myNodeID;
        @(negedge clk);
        outReady = 1'b0;
        sendPacket(first);
        sendPacket(second);
        offerPacket(third);
        // both stages hold a packet
        repeat (3) begin
            @(posedge clk);
            check(inReady, 1'b0, "inReady with both stages full");
        end
        @(negedge clk);
        outReady = 1'b1;
        fork
            waitInAccept();
            begin
                expectPacket(forwarded(first), "stalled packet 1");
                expectPacket(invRipple(second), "stalled packet 2");
                expectPacket(forwarded(third), "stalled packet 3");
            end
        join
    endtask

    initial begin
        seed         = 86;
        cycleCount   = 0;
        clk          = 1'b0;
        nrst         = 1'b0;
        inValid      = 1'b0;
        inPkt        = '0;
        sendValid    = 1'b0;
        role         = 1'b0;
        lowEnergy    = 1'b0;
        myNodeID     = 16'h0042;
        hopsFromSink = 16'd3;
        myQValue     = randWord();
        myEnergy     = randWord();
        hopsFromCH   = 16'd2;
        chosenCH     = 16'h0017;
        chosenHop    = 16'h0023;
        outReady     = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        testHeartbeat();
        testInvitation();
        testTimeout();
        testForwarding();
        testOrigination();
        testBackPressure();
        // let the last edge's assertions settle
        @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/rewardTop_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rewardTop_properties (
    input logic                  clk,
    input logic                  nrst,
    input logic                  inValid,
    input logic                  inReady,
    input packetPkg::pktHeader_t inHeader,
    input logic                  sendValid,
    input logic                  sendReady,
    input logic                  outValid,
    input logic                  outReady,
    input packetPkg::pktHeader_t outHeader,
    input logic                  hbSeen,
    input logic                  dataSeen,
    input logic                  hbLocked
);

    // failed assertions so far
    int failCount = 0;

    // offered packet waits unchanged
    inHold: assert property (@(posedge clk) disable iff (!nrst)
        inValid && !inReady |=> inValid && $stable(inHeader))
        else begin
            $error("incoming packet dropped or changed while stalled");
            failCount++;
        end

    sendHold: assert property (@(posedge clk) disable iff (!nrst)
        sendValid && !sendReady |=> sendValid)
        else begin
            $error("send request withdrawn before sendReady");
            failCount++;
        end

    // packer output held under back-pressure
    outHold: assert property (@(posedge clk) disable iff (!nrst)
        outValid && !outReady |=> outValid && $stable(outHeader))
        else begin
            $error("output header dropped or changed while stalled");
            failCount++;
        end

    outAfterReset: assert property (@(posedge clk)
        $rose(nrst) |-> !outValid)
        else begin
            $error("outValid high right after reset");
            failCount++;
        end

    // first heartbeat sets the lock and data clears it
    lockSet: assert property (@(posedge clk) disable iff (!nrst)
        hbSeen |=> hbLocked)
        else begin
            $error("lock not set after heartbeat");
            failCount++;
        end

    lockClear: assert property (@(posedge clk) disable iff (!nrst)
        dataSeen |=> !hbLocked)
        else begin
            $error("lock still set after DATA");
            failCount++;
        end

endmodule

bind rewardTop rewardTop_properties rewardTop_properties_i (
    .clk      (clk),
    .nrst     (nrst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inHeader (inHeader),
    .sendValid(sendValid),
    .sendReady(sendReady),
    .outValid (outValid),
    .outReady (outReady),
    .outHeader(outHeader),
    .hbSeen   (hbSeen),
    .dataSeen (dataSeen),
    .hbLocked (hbLocked)
);

`default_nettype wire

// File: hw/rewardTop.sv
`timescale 1ns/1ps
`default_nettype none

module rewardTop #(
    parameter int TIMEOUT_CYCLES = rewardPkg::DEFAULT_TIMEOUT,
    parameter int MAX_INV_HOPS   = rewardPkg::DEFAULT_MAX_INV_HOPS
) (
    input  logic                 clk,
    input  logic                 nrst,
    // incoming packet channel
    input  logic                 inValid,
    output logic                 inReady,
    input  packetPkg::pktType_e  inType,
    input  packetPkg::nodeWord_t inSourceID,
    input  packetPkg::nodeWord_t inSourceHops,
    input  packetPkg::nodeWord_t inQValue,
    input  packetPkg::nodeWord_t inEnergy,
    input  packetPkg::nodeWord_t inHopsFromCH,
    input  packetPkg::nodeWord_t inChosenCH,
    input  packetPkg::nodeWord_t inDestID,
    // local data request
    input  logic                 sendValid,
    output logic                 sendReady,
    // node state
    input  logic                 role,
    input  logic                 lowEnergy,
    input  packetPkg::nodeWord_t myNodeID,
    input  packetPkg::nodeWord_t hopsFromSink,
    input  packetPkg::nodeWord_t myQValue,
    input  packetPkg::nodeWord_t myEnergy,
    input  packetPkg::nodeWord_t hopsFromCH,
    input  packetPkg::nodeWord_t chosenCH,
    input  packetPkg::nodeWord_t chosenHop,
    // outgoing header channel
    output logic                 outValid,
    input  logic                 outReady,
    output packetPkg::pktType_e  outType,
    output packetPkg::nodeWord_t outSourceID,
    output packetPkg::nodeWord_t outSourceHops,
    output packetPkg::nodeWord_t outQValue,
    output packetPkg::nodeWord_t outEnergy,
    output packetPkg::nodeWord_t outHopsFromCH,
    output packetPkg::nodeWord_t outChosenCH,
    output packetPkg::nodeWord_t outDestID
);

    import packetPkg::*;

    pktHeader_t inHeader;
    pktHeader_t outHeader;
    logic       expired;
    logic       expireTaken;
    logic       hbLocked;
    logic       hbSeen;
    logic       dataSeen;
    logic       pktTaken;

    decisionIf decBus ();

    // gather loose input fields
    assign inHeader.pktType    = inType;
    assign inHeader.sourceID   = inSourceID;
    assign inHeader.sourceHops = inSourceHops;
    assign inHeader.qValue     = inQValue;
    assign inHeader.energy     = inEnergy;
    assign inHeader.hopsFromCH = inHopsFromCH;
    assign inHeader.chosenCH   = inChosenCH;
    assign inHeader.destID     = inDestID;

    // lock plus idle timer
    hbTimeout #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) hbTimeout_i (
        .clk        (clk),
        .nrst       (nrst),
        .hbSeen     (hbSeen),
        .dataSeen   (dataSeen),
        .pktTaken   (pktTaken),
        .expireTaken(expireTaken),
        .expired    (expired),
        .hbLocked   (hbLocked)
    );

    // stage 1
    rewardDecide #(
        .MAX_INV_HOPS(MAX_INV_HOPS)
    ) rewardDecide_i (
        .clk        (clk),
        .nrst       (nrst),
        .inValid    (inValid),
        .sendValid  (sendValid),
        .expired    (expired),
        .hbLocked   (hbLocked),
        .role       (role),
        .lowEnergy  (lowEnergy),
        .inHeader   (inHeader),
        .myNodeID   (myNodeID),
        .inReady    (inReady),
        .sendReady  (sendReady),
        .expireTaken(expireTaken),
        .hbSeen     (hbSeen),
        .dataSeen   (dataSeen),
        .pktTaken   (pktTaken),
        .dec        (decBus.decide)
    );

    // stage 2
    packetPacker packetPacker_i (
        .clk         (clk),
        .nrst        (nrst),
        .outReady    (outReady),
        .myNodeID    (myNodeID),
        .hopsFromSink(hopsFromSink),
        .myQValue    (myQValue),
        .myEnergy    (myEnergy),
        .hopsFromCH  (hopsFromCH),
        .chosenCH    (chosenCH),
        .chosenHop   (chosenHop),
        .dec         (decBus.pack),
        .outValid    (outValid),
        .outHeader   (outHeader)
    );

    // spread the packed header onto the output pins
    assign outType       = outHeader.pktType;
    assign outSourceID   = outHeader.sourceID;
    assign outSourceHops = outHeader.sourceHops;
    assign outQValue     = outHeader.qValue;
    assign outEnergy     = outHeader.energy;
    assign outHopsFromCH = outHeader.hopsFromCH;
    assign outChosenCH   = outHeader.chosenCH;
    assign outDestID     = outHeader.destID;

endmodule

`default_nettype wire

// File: hw/packetPacker.sv
`timescale 1ns/1ps
`default_nettype none

module packetPacker (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  outReady,
    input  packetPkg::nodeWord_t  myNodeID,
    input  packetPkg::nodeWord_t  hopsFromSink,
    input  packetPkg::nodeWord_t  myQValue,
    input  packetPkg::nodeWord_t  myEnergy,
    input  packetPkg::nodeWord_t  hopsFromCH,
    input  packetPkg::nodeWord_t  chosenCH,
    input  packetPkg::nodeWord_t  chosenHop,
    decisionIf.pack               dec,
    output logic                  outValid,
    output packetPkg::pktHeader_t outHeader
);

    import packetPkg::*;
    import rewardPkg::*;

    logic       canLoad;
    nodeWord_t  nextHop;
    pktHeader_t built;

    // hold until the downstream side takes the header
    assign canLoad   = !outValid || outReady;
    assign dec.ready = canLoad;

    // one hop from sink means talk to the sink directly
    assign nextHop = (hopsFromSink == 16'd1) ? SINK_ID : chosenHop;

    // header assembly, unnamed fields stay zero
    always_comb begin
        built = '0;
        case (dec.kind)
            RIPPLE_HB: begin
                built.pktType    = HB;
                built.sourceID   = myNodeID;
                built.sourceHops = dec.header.sourceHops + 16'd1;
                built.destID     = BROADCAST_ID;
            end
            RIPPLE_INV: begin
                // CH identity travels unchanged, distance grows by one
                built.pktType    = INV;
                built.sourceID   = dec.header.sourceID;
                built.qValue     = dec.header.qValue;
                built.hopsFromCH = dec.header.hopsFromCH + 16'd1;
                built.destID     = BROADCAST_ID;
            end
            SEND_MR: begin
                built.pktType    = MR;
                built.sourceID   = myNodeID;
                built.sourceHops = hopsFromSink;
                built.qValue     = myQValue;
                built.energy     = myEnergy;
                built.hopsFromCH = hopsFromCH;
                built.destID     = chosenCH;
            end
            SEND_CHT: begin
                built.pktType  = CHT;
                built.sourceID = myNodeID;
                built.qValue   = myQValue;
                built.chosenCH = myNodeID;
                built.destID   = BROADCAST_ID;
            end
            FORWARD: begin
                // relay keeps everything but the address
                built        = dec.header;
                built.destID = nextHop;
            end
            ORIGINATE: begin
                // DATA or SOS picked upstream
                built.pktType    = dec.header.pktType;
                built.sourceID   = myNodeID;
                built.sourceHops = hopsFromSink;
                built.qValue     = myQValue;
                built.energy     = myEnergy;
                built.hopsFromCH = hopsFromCH;
                built.chosenCH   = chosenCH;
                built.destID     = nextHop;
            end
            default: begin
                built.pktType = NONE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            outValid <= 1'b0;
        end else if (canLoad) begin
            outValid <= dec.valid;
        end
    end

    // node fields sampled at load time
    always_ff @(posedge clk) begin
        if (canLoad && dec.valid) begin
            outHeader <= built;
        end
    end

endmodule

`default_nettype wire

// File: hw/rewardDecide.sv
`timescale 1ns/1ps
`default_nettype none

module rewardDecide #(
    parameter int MAX_INV_HOPS = rewardPkg::DEFAULT_MAX_INV_HOPS
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 inValid,
    input  logic                 sendValid,
    input  logic                 expired,
    input  logic                 hbLocked,
    input  logic                 role,
    input  logic                 lowEnergy,
    input  packetPkg::pktHeader_t inHeader,
    input  packetPkg::nodeWord_t  myNodeID,
    output logic                 inReady,
    output logic                 sendReady,
    output logic                 expireTaken,
    output logic                 hbSeen,
    output logic                 dataSeen,
    output logic                 pktTaken,
    decisionIf.decide            dec
);

    import packetPkg::*;
    import rewardPkg::*;

    localparam nodeWord_t INV_LIMIT = nodeWord_t'(MAX_INV_HOPS);

    logic        canAccept;
    logic        hit;
    rewardKind_e nextKind;
    pktHeader_t  nextHeader;

    // register free now, or emptied by the packer on this edge
    assign canAccept = !dec.valid || dec.ready;

    // fixed priority: packet, then expiry, then local send
    assign inReady     = canAccept;
    assign expireTaken = canAccept && !inValid && expired;
    assign sendReady   = canAccept && !inValid && !expired;

    // strobes toward the lock and the timer
    assign pktTaken = inValid && inReady;
    assign hbSeen   = pktTaken && inHeader.pktType == HB;
    assign dataSeen = pktTaken && inHeader.pktType == DATA;

    // classify the winning event
    // hit low means consume without answering
    always_comb begin
        hit        = 1'b0;
        nextKind   = RIPPLE_HB;
        nextHeader = '0;
        if (inValid) begin
            nextHeader = inHeader;
            case (inHeader.pktType)
                HB: begin
                    // only the first heartbeat gets rippled
                    if (!hbLocked) begin
                        hit      = 1'b1;
                        nextKind = RIPPLE_HB;
                    end
                end
                INV: begin
                    if (inHeader.hopsFromCH < INV_LIMIT) begin
                        hit      = 1'b1;
                        nextKind = RIPPLE_INV;
                    end
                end
                DATA, SOS: begin
                    // relay only traffic addressed here
                    if (inHeader.destID == myNodeID) begin
                        hit      = 1'b1;
                        nextKind = FORWARD;
                    end
                end
                default: begin
                    // CHE, MR, CHT end here
                    hit = 1'b0;
                end
            endcase
        end else if (expired) begin
            hit = 1'b1;
            // cluster head announces slots, member asks to join
            if (role) begin
                nextKind = SEND_CHT;
            end else begin
                nextKind = SEND_MR;
            end
        end else if (sendValid) begin
            hit      = 1'b1;
            nextKind = ORIGINATE;
            if (lowEnergy) begin
                nextHeader.pktType = SOS;
            end else begin
                nextHeader.pktType = DATA;
            end
        end
    end

    // occupancy follows hit whenever the slot can change
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            dec.valid <= 1'b0;
        end else if (canAccept) begin
            dec.valid <= hit;
        end
    end

    // payload only written on a real decision
    always_ff @(posedge clk) begin
        if (canAccept && hit) begin
            dec.kind   <= nextKind;
            dec.header <= nextHeader;
        end
    end

endmodule

`default_nettype wire

// File: hw/hbTimeout.sv
`timescale 1ns/1ps
`default_nettype none

module hbTimeout #(
    parameter int TIMEOUT_CYCLES = rewardPkg::DEFAULT_TIMEOUT
) (
    input  logic clk,
    input  logic nrst,
    input  logic hbSeen,
    input  logic dataSeen,
    input  logic pktTaken,
    input  logic expireTaken,
    output logic expired,
    output logic hbLocked
);

    // wide enough to hold the reload value itself
    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] count;
    logic             reload;

    // lock set by first heartbeat, released by data traffic
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hbLocked <= 1'b0;
        end else if (dataSeen) begin
            hbLocked <= 1'b0;
        end else if (hbSeen) begin
            hbLocked <= 1'b1;
        end
    end

    // counter parked at full value while unlocked
    // any accepted packet or a consumed expiry restarts the wait
    assign reload = !hbLocked || pktTaken || expireTaken;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= CNT_W'(TIMEOUT_CYCLES);
        end else if (reload) begin
            count <= CNT_W'(TIMEOUT_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // expiry flag rises on the edge that takes count from 1 to 0
    // sticky until the decision stage takes it or the lock drops
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            expired <= 1'b0;
        end else if (expireTaken || !hbLocked) begin
            expired <= 1'b0;
        end else if (!pktTaken && count == CNT_W'(1)) begin
            expired <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/decisionIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decisionIf;

    import packetPkg::*;
    import rewardPkg::*;

    // stage-to-stage handshake
    logic        valid;
    logic        ready;

    // decided action for the packer
    rewardKind_e kind;

    // header as captured at the decision point
    // only the type field is meaningful for originated packets
    pktHeader_t  header;

    // decision stage is the producer
    modport decide (
        output valid,
        output kind,
        output header,
        input  ready
    );

    // packer is the consumer
    modport pack (
        input  valid,
        input  kind,
        input  header,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/rewardPkg.sv
`default_nettype none

package rewardPkg;

    // what the decision stage asks the packer to build
    typedef enum logic [2:0] {
        RIPPLE_HB  = 3'd0,
        RIPPLE_INV = 3'd1,
        SEND_MR    = 3'd2,
        SEND_CHT   = 3'd3,
        FORWARD    = 3'd4,
        ORIGINATE  = 3'd5
    } rewardKind_e;

    // idle cycles after the last packet before MR / CHT goes out
    localparam int DEFAULT_TIMEOUT = 10;

    // invitations at or beyond this CH distance stop rippling
    localparam int DEFAULT_MAX_INV_HOPS = 4;

endpackage

`default_nettype wire

// File: hw/packetPkg.sv
`default_nettype none

package packetPkg;

    // every header field is one 16-bit word
    typedef logic [15:0] nodeWord_t;

    // packet type codes as carried on air
    typedef enum logic [2:0] {
        HB   = 3'd0,
        CHE  = 3'd1,
        INV  = 3'd2,
        MR   = 3'd3,
        CHT  = 3'd4,
        DATA = 3'd5,
        SOS  = 3'd6,
        NONE = 3'd7
    } pktType_e;

    // 3 + 7 * 16 = 115 bits
    typedef struct packed {
        pktType_e  pktType;
        nodeWord_t sourceID;
        nodeWord_t sourceHops;
        nodeWord_t qValue;
        nodeWord_t energy;
        nodeWord_t hopsFromCH;
        nodeWord_t chosenCH;
        nodeWord_t destID;
    } pktHeader_t;

    // destination for flooded packets
    localparam nodeWord_t BROADCAST_ID = 16'hFFFF;
    // sink always sits at address 0
    localparam nodeWord_t SINK_ID = 16'h0000;

endpackage

`default_nettype wire
